// ==== rtl/qm_pkg.sv ====
package qm_pkg;

////////////////////////////////////////
// Sizes
////////////////////////////////////////

localparam int NB_QUEUES         = 16;
localparam int QUEUE_ID_W        = 4;
localparam int RB_AW             = 12;
localparam int PKT_SIZE_W        = 6;
localparam int META_W            = 8;
localparam int OUT_FIFO_DEPTH    = 16;
// Input stalls once the FIFO holds more than this
localparam int ALMOST_FULL_LEVEL = 8;
localparam int APB_AW            = 8;

typedef logic [QUEUE_ID_W-1:0] queue_id_t;
typedef logic [RB_AW-1:0]      rb_ptr_t;
typedef logic [PKT_SIZE_W-1:0] pkt_size_t;
typedef logic [META_W-1:0]     meta_t;
typedef logic [RB_AW:0]        ring_size_t;

typedef struct packed {
    rb_ptr_t head;
    rb_ptr_t tail;
    logic    drop;
    meta_t   meta;
} out_entry_t;

////////////////////////////////////////
// APB register map
////////////////////////////////////////

localparam logic [APB_AW-1:0] REG_RING_SIZE = 8'h00;
localparam logic [APB_AW-1:0] REG_DROP_CNT  = 8'h04;
// One word per queue starting at each base
localparam logic [APB_AW-1:0] REG_HEAD_BASE = 8'h40;
localparam logic [APB_AW-1:0] REG_TAIL_BASE = 8'h80;

localparam ring_size_t RING_SIZE_RESET = 256;

endpackage

// ==== rtl/queue_table.sv ====
`timescale 1ns/1ps

module queue_table
    import qm_pkg::*;
(
    input  logic      clk,

    input  queue_id_t a_addr,
    input  logic      a_rd_en,
    input  logic      a_wr_en,
    input  rb_ptr_t   a_wr_data,
    output rb_ptr_t   a_rd_data,

    input  queue_id_t b_addr,
    input  logic      b_rd_en,
    input  logic      b_wr_en,
    input  rb_ptr_t   b_wr_data,
    output rb_ptr_t   b_rd_data
);

// All pointers start at zero
rb_ptr_t mem [NB_QUEUES] = '{default: '0};

rb_ptr_t a_rd_r;
rb_ptr_t b_rd_r;

always_ff @(posedge clk) begin
    if (a_wr_en) begin
        mem[a_addr] <= a_wr_data;
    end
    if (b_wr_en) begin
        mem[b_addr] <= b_wr_data;
    end
end

// Array read, then output register on each port
always_ff @(posedge clk) begin
    if (a_rd_en) begin
        a_rd_r <= mem[a_addr];
    end
    if (b_rd_en) begin
        b_rd_r <= mem[b_addr];
    end
    a_rd_data <= a_rd_r;
    b_rd_data <= b_rd_r;
end

endmodule

// ==== rtl/queue_state_fetch.sv ====
`timescale 1ns/1ps

module queue_state_fetch
    import qm_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // Pipeline read request
    input  logic      rd_en,
    input  queue_id_t rd_queue_in,

    // Tail write-back
    input  logic      tail_wr_en,
    input  queue_id_t wr_queue,
    input  rb_ptr_t   new_tail,

    // Host side
    input  logic      head_wr_en,
    input  queue_id_t head_wr_queue,
    input  rb_ptr_t   head_wr_data,
    input  logic      tail_rd_en,
    input  queue_id_t tail_rd_queue,
    output rb_ptr_t   tail_rd_data,

    output logic      state_valid,
    output rb_ptr_t   head,
    output rb_ptr_t   tail,
    output queue_id_t state_queue
);

logic      head_bypass;
logic      bypass_r;
logic      bypass_r2;
logic      rd_en_r;
logic      rd_en_r2;
queue_id_t rd_queue_r;
queue_id_t rd_queue_r2;
rb_ptr_t   head_wr_data_r;
rb_ptr_t   head_wr_data_r2;
rb_ptr_t   head_rd_data;
queue_id_t tail_a_addr;
logic      tail_a_wr_en;

// A host write to the head being read supplies the head value instead
assign head_bypass = rd_en && head_wr_en && (head_wr_queue == rd_queue_in);

// Reads win on the shared port a of the tail table
assign tail_a_addr  = rd_en ? rd_queue_in : wr_queue;
assign tail_a_wr_en = tail_wr_en && !rd_en;

queue_table heads_table (
    .clk       (clk),
    .a_addr    (rd_queue_in),
    .a_rd_en   (rd_en && !head_bypass),
    .a_wr_en   (1'b0),
    .a_wr_data ('0),
    .a_rd_data (head_rd_data),
    .b_addr    (head_wr_queue),
    .b_rd_en   (1'b0),
    .b_wr_en   (head_wr_en),
    .b_wr_data (head_wr_data),
    .b_rd_data ()
);

queue_table tails_table (
    .clk       (clk),
    .a_addr    (tail_a_addr),
    .a_rd_en   (rd_en),
    .a_wr_en   (tail_a_wr_en),
    .a_wr_data (new_tail),
    .a_rd_data (tail),
    .b_addr    (tail_rd_queue),
    .b_rd_en   (tail_rd_en),
    .b_wr_en   (1'b0),
    .b_wr_data ('0),
    .b_rd_data (tail_rd_data)
);

// Track the read through the two table stages
always_ff @(posedge clk) begin
    if (rst) begin
        rd_en_r   <= 1'b0;
        rd_en_r2  <= 1'b0;
        bypass_r  <= 1'b0;
        bypass_r2 <= 1'b0;
    end else begin
        rd_en_r   <= rd_en;
        rd_en_r2  <= rd_en_r;
        bypass_r  <= head_bypass;
        bypass_r2 <= bypass_r;
    end
end

always_ff @(posedge clk) begin
    rd_queue_r      <= rd_queue_in;
    rd_queue_r2     <= rd_queue_r;
    head_wr_data_r  <= head_wr_data;
    head_wr_data_r2 <= head_wr_data_r;
end

assign state_valid = rd_en_r2;
assign state_queue = rd_queue_r2;
assign head        = bypass_r2 ? head_wr_data_r2 : head_rd_data;

endmodule

// ==== rtl/tail_update.sv ====
`timescale 1ns/1ps

module tail_update
    import qm_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  queue_id_t   in_queue_id,
    input  pkt_size_t   in_size,
    input  logic        in_pass_through,
    input  meta_t       in_meta,
    input  logic        in_valid,
    output logic        in_ready,

    output logic        rd_en,
    output queue_id_t   rd_queue,
    input  logic        state_valid,
    input  rb_ptr_t     head,
    input  rb_ptr_t     tail,
    input  queue_id_t   state_queue,

    input  ring_size_t  ring_size,
    input  logic        almost_full,

    output logic        tail_wr_en,
    output queue_id_t   wr_queue,
    output rb_ptr_t     new_tail,
    output logic        push,
    output out_entry_t  push_entry,
    output logic [31:0] drop_cnt
);

typedef struct packed {
    pkt_size_t size;
    logic      pass_through;
    meta_t     meta;
} pkt_info_t;

// Metadata waits here while the queue state is fetched
pkt_info_t dly [3];
pkt_info_t cur;

logic      accept;
rb_ptr_t   mask;
rb_ptr_t   cur_tail;
rb_ptr_t   free_slots;
rb_ptr_t   next_tail;
logic      drop;

// Slot 1 holds the decision of the last cycle and slot 0 the one before
logic      last_valid [2];
queue_id_t last_queue [2];
rb_ptr_t   last_tail [2];

assign cur    = dly[0];
assign accept = in_valid && in_ready;
assign mask   = rb_ptr_t'(ring_size - 1'b1);

// No new read in a cycle whose decision writes a tail back
assign in_ready = !almost_full && !(state_valid && !cur.pass_through);

////////////////////////////////////////
// Room check
////////////////////////////////////////

always_comb begin
    // The newest matching decision overrides a stale table tail
    cur_tail = tail;
    if (last_valid[1] && (last_queue[1] == state_queue)) begin
        cur_tail = last_tail[1];
    end else if (last_valid[0] && (last_queue[0] == state_queue)) begin
        cur_tail = last_tail[0];
    end

    free_slots = (head - cur_tail - 1'b1) & mask;
    drop       = !cur.pass_through && (free_slots < rb_ptr_t'(cur.size));

    if (drop || cur.pass_through) begin
        next_tail = cur_tail;
    end else begin
        next_tail = (cur_tail + rb_ptr_t'(cur.size)) & mask;
    end
end

assign push = state_valid;

always_comb begin
    push_entry.head = head;
    push_entry.tail = cur_tail;
    push_entry.drop = drop;
    push_entry.meta = cur.meta;
end

////////////////////////////////////////
// Decision and read issue
////////////////////////////////////////

always_ff @(posedge clk) begin
    if (rst) begin
        rd_en         <= 1'b0;
        tail_wr_en    <= 1'b0;
        last_valid[0] <= 1'b0;
        last_valid[1] <= 1'b0;
        drop_cnt      <= '0;
    end else begin
        rd_en         <= accept;
        tail_wr_en    <= state_valid && !drop && !cur.pass_through;
        last_valid[1] <= state_valid;
        last_valid[0] <= last_valid[1];
        if (state_valid && drop) begin
            drop_cnt <= drop_cnt + 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    if (accept) begin
        rd_queue <= in_queue_id;
        dly[2]   <= '{size: in_size, pass_through: in_pass_through, meta: in_meta};
    end
    dly[1] <= dly[2];
    dly[0] <= dly[1];

    if (state_valid) begin
        last_queue[1] <= state_queue;
        last_tail[1]  <= next_tail;
    end
    last_queue[0] <= last_queue[1];
    last_tail[0]  <= last_tail[1];
end

// Write-back uses the newest decision
assign wr_queue = last_queue[1];
assign new_tail = last_tail[1];

endmodule

// ==== rtl/out_fifo.sv ====
`timescale 1ns/1ps

module out_fifo
    import qm_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  logic       push,
    input  out_entry_t push_entry,
    output logic       almost_full,

    output out_entry_t out_entry,
    output logic       out_valid,
    input  logic       out_ready
);

localparam int PTR_W = $clog2(OUT_FIFO_DEPTH);

out_entry_t mem [OUT_FIFO_DEPTH];

logic [PTR_W-1:0] wr_ptr;
logic [PTR_W-1:0] rd_ptr;
logic [PTR_W:0]   count;
logic             pop;

assign pop         = out_valid && out_ready;
assign out_valid   = (count != '0);
assign out_entry   = mem[rd_ptr];
assign almost_full = (count > ALMOST_FULL_LEVEL);

always_ff @(posedge clk) begin
    if (push) begin
        mem[wr_ptr] <= push_entry;
    end
end

// Pointers wrap naturally since the depth is a power of two
always_ff @(posedge clk) begin
    if (rst) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else begin
        if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
        if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
        case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
        endcase
    end
end

endmodule

// ==== rtl/apb_csr.sv ====
`timescale 1ns/1ps

module apb_csr
    import qm_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    input  logic [APB_AW-1:0] paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,

    output ring_size_t        ring_size,
    output logic              head_wr_en,
    output queue_id_t         head_wr_queue,
    output rb_ptr_t           head_wr_data,
    output logic              tail_rd_en,
    output queue_id_t         tail_rd_queue,
    input  rb_ptr_t           tail_rd_data,
    input  logic [31:0]       drop_cnt
);

localparam int QSEL_LO = QUEUE_ID_W + 2;

logic       access;
logic       is_head;
logic       is_tail;
logic       tail_rd_req;
logic [1:0] wait_cnt;

assign access  = psel && penable;
assign is_head = (paddr[APB_AW-1:QSEL_LO] == REG_HEAD_BASE[APB_AW-1:QSEL_LO]);
assign is_tail = (paddr[APB_AW-1:QSEL_LO] == REG_TAIL_BASE[APB_AW-1:QSEL_LO]);

// Head writes go straight to table port b
assign head_wr_en    = access && pwrite && is_head;
assign head_wr_queue = paddr[QSEL_LO-1:2];
assign head_wr_data  = pwdata[RB_AW-1:0];

// A tail read issues on the first access cycle and returns data two cycles later
assign tail_rd_req   = access && !pwrite && is_tail;
assign tail_rd_en    = tail_rd_req && (wait_cnt == 2'd0);
assign tail_rd_queue = paddr[QSEL_LO-1:2];
assign pready        = access && (!tail_rd_req || (wait_cnt == 2'd2));

always_ff @(posedge clk) begin
    if (rst) begin
        wait_cnt  <= 2'd0;
        ring_size <= RING_SIZE_RESET;
    end else begin
        if (tail_rd_req && !pready) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= 2'd0;
        end
        if (access && pwrite && (paddr == REG_RING_SIZE)) begin
            ring_size <= pwdata[RB_AW:0];
        end
    end
end

always_comb begin
    prdata = '0;
    if (paddr == REG_RING_SIZE) begin
        prdata = 32'(ring_size);
    end else if (paddr == REG_DROP_CNT) begin
        prdata = drop_cnt;
    end else if (is_tail) begin
        prdata = 32'(tail_rd_data);
    end
end

endmodule

// ==== rtl/queue_manager.sv ====
`timescale 1ns/1ps

module queue_manager
    import qm_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    // Input metadata stream
    input  queue_id_t         in_queue_id,
    input  pkt_size_t         in_size,
    input  logic              in_pass_through,
    input  meta_t             in_meta,
    input  logic              in_valid,
    output logic              in_ready,

    // Decided entries
    output rb_ptr_t           out_head,
    output rb_ptr_t           out_tail,
    output logic              out_drop,
    output meta_t             out_meta,
    output logic              out_valid,
    input  logic              out_ready,

    // Host APB
    input  logic [APB_AW-1:0] paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready
);

ring_size_t  ring_size;
logic        head_wr_en;
queue_id_t   head_wr_queue;
rb_ptr_t     head_wr_data;
logic        tail_rd_en;
queue_id_t   tail_rd_queue;
rb_ptr_t     tail_rd_data;
logic [31:0] drop_cnt;

logic        rd_en;
queue_id_t   rd_queue;
logic        state_valid;
rb_ptr_t     head;
rb_ptr_t     tail;
queue_id_t   state_queue;
logic        tail_wr_en;
queue_id_t   wr_queue;
rb_ptr_t     new_tail;

logic        push;
out_entry_t  push_entry;
logic        almost_full;
out_entry_t  out_entry;

apb_csr csr0 (
    .clk           (clk),
    .rst           (rst),
    .paddr         (paddr),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .ring_size     (ring_size),
    .head_wr_en    (head_wr_en),
    .head_wr_queue (head_wr_queue),
    .head_wr_data  (head_wr_data),
    .tail_rd_en    (tail_rd_en),
    .tail_rd_queue (tail_rd_queue),
    .tail_rd_data  (tail_rd_data),
    .drop_cnt      (drop_cnt)
);

queue_state_fetch fetch0 (
    .clk           (clk),
    .rst           (rst),
    .rd_en         (rd_en),
    .rd_queue_in   (rd_queue),
    .tail_wr_en    (tail_wr_en),
    .wr_queue      (wr_queue),
    .new_tail      (new_tail),
    .head_wr_en    (head_wr_en),
    .head_wr_queue (head_wr_queue),
    .head_wr_data  (head_wr_data),
    .tail_rd_en    (tail_rd_en),
    .tail_rd_queue (tail_rd_queue),
    .tail_rd_data  (tail_rd_data),
    .state_valid   (state_valid),
    .head          (head),
    .tail          (tail),
    .state_queue   (state_queue)
);

tail_update update0 (
    .clk             (clk),
    .rst             (rst),
    .in_queue_id     (in_queue_id),
    .in_size         (in_size),
    .in_pass_through (in_pass_through),
    .in_meta         (in_meta),
    .in_valid        (in_valid),
    .in_ready        (in_ready),
    .rd_en           (rd_en),
    .rd_queue        (rd_queue),
    .state_valid     (state_valid),
    .head            (head),
    .tail            (tail),
    .state_queue     (state_queue),
    .ring_size       (ring_size),
    .almost_full     (almost_full),
    .tail_wr_en      (tail_wr_en),
    .wr_queue        (wr_queue),
    .new_tail        (new_tail),
    .push            (push),
    .push_entry      (push_entry),
    .drop_cnt        (drop_cnt)
);

out_fifo fifo0 (
    .clk         (clk),
    .rst         (rst),
    .push        (push),
    .push_entry  (push_entry),
    .almost_full (almost_full),
    .out_entry   (out_entry),
    .out_valid   (out_valid),
    .out_ready   (out_ready)
);

// Unpack the FIFO head onto the output stream
assign out_head = out_entry.head;
assign out_tail = out_entry.tail;
assign out_drop = out_entry.drop;
assign out_meta = out_entry.meta;

endmodule

// ==== testbench/tb_queue_manager.sv ====
`timescale 1ns/1ps

module tb_queue_manager
    import qm_pkg::*;
();

localparam int CLK_HALF  = 20;
localparam int SEED      = 32'h23525eea;
localparam int MAX_ITEMS = 64;
// Under 70 items of at most about 50 cycles each plus APB traffic
localparam int WATCHDOG_CYCLES = 20000;

logic              clk;
logic              rst;
queue_id_t         in_queue_id;
pkt_size_t         in_size;
logic              in_pass_through;
meta_t             in_meta;
logic              in_valid;
logic              in_ready;
rb_ptr_t           out_head;
rb_ptr_t           out_tail;
logic              out_drop;
meta_t             out_meta;
logic              out_valid;
logic              out_ready;
logic [APB_AW-1:0] paddr;
logic              psel;
logic              penable;
logic              pwrite;
logic [31:0]       pwdata;
logic [31:0]       prdata;
logic              pready;

// Reference model of the ring state
rb_ptr_t    model_head [NB_QUEUES];
rb_ptr_t    model_tail [NB_QUEUES];
int         ring_size_m;
int         drop_total;
out_entry_t expected [$];

int errors;
int checks;
int max_low_run;

// Items of the next burst
queue_id_t b_queue [MAX_ITEMS];
pkt_size_t b_size [MAX_ITEMS];
logic      b_pt [MAX_ITEMS];
meta_t     b_meta [MAX_ITEMS];
int        b_hold [MAX_ITEMS];

queue_manager dut0 (
    .clk             (clk),
    .rst             (rst),
    .in_queue_id     (in_queue_id),
    .in_size         (in_size),
    .in_pass_through (in_pass_through),
    .in_meta         (in_meta),
    .in_valid        (in_valid),
    .in_ready        (in_ready),
    .out_head        (out_head),
    .out_tail        (out_tail),
    .out_drop        (out_drop),
    .out_meta        (out_meta),
    .out_valid       (out_valid),
    .out_ready       (out_ready),
    .paddr           (paddr),
    .psel            (psel),
    .penable         (penable),
    .pwrite          (pwrite),
    .pwdata          (pwdata),
    .prdata          (prdata),
    .pready          (pready)
);

initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
end

initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("ERROR: watchdog expired after %0d cycles, DUT stopped responding", WATCHDOG_CYCLES);
    $display("*** FAILED ***");
    $finish;
end

////////////////////////////////////////
// Checking and bus tasks
////////////////////////////////////////

task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("FAIL t=%0t %s expected %0h actual %0h", $time, name, exp, act);
    end
endtask

task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [31:0] data);
    paddr   = addr;
    pwdata  = data;
    pwrite  = 1'b1;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #2;
    penable = 1'b1;
    @(negedge clk);
    while (!pready) begin
        @(negedge clk);
    end
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
endtask

task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [31:0] data);
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #2;
    penable = 1'b1;
    @(negedge clk);
    while (!pready) begin
        @(negedge clk);
    end
    data = prdata;
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
endtask

task automatic set_head(input int q, input rb_ptr_t h);
    apb_write(REG_HEAD_BASE + APB_AW'(4 * q), 32'(h));
    model_head[q] = h;
endtask

task automatic set_ring(input int size);
    apb_write(REG_RING_SIZE, 32'(size));
    ring_size_m = size;
endtask

task automatic compare_tail(input int q);
    logic [31:0] data;
    apb_read(REG_TAIL_BASE + APB_AW'(4 * q), data);
    check($sformatf("tail[%0d]", q), 32'(model_tail[q]), data);
endtask

task automatic compare_drop_count();
    logic [31:0] data;
    apb_read(REG_DROP_CNT, data);
    check("drop_cnt", 32'(drop_total), data);
endtask

////////////////////////////////////////
// Stream tasks
////////////////////////////////////////

// Applies the decision rule to the model, then offers the item
task automatic send_item(input queue_id_t q, input pkt_size_t size, input logic pt,
                         input meta_t meta);
    rb_ptr_t    mask;
    rb_ptr_t    free_slots;
    out_entry_t e;
    int         low_run;
    mask       = rb_ptr_t'(ring_size_m - 1);
    free_slots = (model_head[q] - model_tail[q] - 1'b1) & mask;
    e.head = model_head[q];
    e.tail = model_tail[q];
    e.drop = !pt && (free_slots < rb_ptr_t'(size));
    e.meta = meta;
    if (e.drop) begin
        drop_total++;
    end else if (!pt) begin
        model_tail[q] = (model_tail[q] + rb_ptr_t'(size)) & mask;
    end
    expected.push_back(e);

    in_queue_id     = q;
    in_size         = size;
    in_pass_through = pt;
    in_meta         = meta;
    in_valid        = 1'b1;
    low_run         = 0;
    @(negedge clk);
    while (!in_ready) begin
        low_run++;
        if (low_run > max_low_run) begin
            max_low_run = low_run;
        end
        @(negedge clk);
    end
    @(posedge clk);
    #2;
    in_valid = 1'b0;
endtask

task automatic recv_item(input int hold_low);
    out_entry_t e;
    out_ready = 1'b0;
    if (hold_low > 0) begin
        repeat (hold_low) @(posedge clk);
        #2;
    end
    out_ready = 1'b1;
    @(negedge clk);
    while (!out_valid) begin
        @(negedge clk);
    end
    if (expected.size() == 0) begin
        errors++;
        $display("ERROR: output entry at %0t with no item outstanding", $time);
    end else begin
        e = expected.pop_front();
        check("out_head", 32'(e.head), 32'(out_head));
        check("out_tail", 32'(e.tail), 32'(out_tail));
        check("out_drop", 32'(e.drop), 32'(out_drop));
        check("out_meta", 32'(e.meta), 32'(out_meta));
    end
    @(posedge clk);
    #2;
    out_ready = 1'b0;
endtask

task automatic set_item(input int i, input int q, input int size, input int pt,
                        input int hold);
    b_queue[i] = queue_id_t'(q);
    b_size[i]  = pkt_size_t'(size);
    b_pt[i]    = (pt != 0);
    b_meta[i]  = meta_t'($urandom);
    b_hold[i]  = hold;
endtask

task automatic run_burst(input int n);
    fork
        begin
            for (int i = 0; i < n; i++) begin
                send_item(b_queue[i], b_size[i], b_pt[i], b_meta[i]);
            end
        end
        begin
            for (int j = 0; j < n; j++) begin
                recv_item(b_hold[j]);
            end
        end
    join
endtask

////////////////////////////////////////
// Directed tests
////////////////////////////////////////

task automatic test_reset_values();
    logic [31:0] data;
    @(negedge clk);
    check("in_ready", 32'd1, 32'(in_ready));
    check("out_valid", 32'd0, 32'(out_valid));
    @(posedge clk);
    #2;
    apb_read(REG_RING_SIZE, data);
    check("ring_size", 32'd256, data);
    compare_drop_count();
    for (int q = 0; q < NB_QUEUES; q++) begin
        compare_tail(q);
    end
endtask

task automatic test_single_items();
    for (int q = 0; q < 4; q++) begin
        set_head(q, rb_ptr_t'(200));
    end
    for (int i = 0; i < 8; i++) begin
        set_item(0, i % 4, 1 + $urandom % 32, 0, 0);
        run_burst(1);
    end
    for (int q = 0; q < 4; q++) begin
        compare_tail(q);
    end
endtask

// Head just behind the tail leaves 62 free slots and each round fills at most 60
task automatic test_back_to_back();
    set_ring(64);
    for (int r = 0; r < 3; r++) begin
        set_head(5, (model_tail[5] - 1'b1) & rb_ptr_t'(ring_size_m - 1));
        for (int i = 0; i < 4; i++) begin
            set_item(i, 5, 1 + $urandom % 15, 0, 0);
        end
        run_burst(4);
    end
    compare_tail(5);
endtask

task automatic test_drops();
    set_head(7, rb_ptr_t'(20));
    set_item(0, 7, 8, 0, 0);
    set_item(1, 7, 8, 0, 0);
    set_item(2, 7, 8, 0, 0);
    set_item(3, 7, 5, 0, 0);
    set_item(4, 7, 3, 0, 0);
    run_burst(5);
    compare_tail(7);
    compare_drop_count();
endtask

task automatic test_pass_through();
    for (int i = 0; i < 3; i++) begin
        set_item(i, 7, 4, 1, 0);
    end
    run_burst(3);
    compare_tail(7);
    compare_drop_count();
endtask

task automatic test_back_pressure();
    int hold;
    for (int q = 8; q < 12; q++) begin
        set_head(q, (model_tail[q] - 1'b1) & rb_ptr_t'(ring_size_m - 1));
    end
    max_low_run = 0;
    for (int i = 0; i < 40; i++) begin
        hold = (i == 0 || $urandom % 4 == 0) ? 20 + $urandom % 20 : 0;
        set_item(i, 8 + $urandom % 4, 1 + $urandom % 8, ($urandom % 8 == 0), hold);
    end
    run_burst(40);
    // A stall of this length only comes from a full FIFO
    if (max_low_run < 8) begin
        errors++;
        $display("ERROR: in_ready never stayed low under back-pressure (longest %0d cycles)",
                 max_low_run);
    end
    compare_drop_count();
    for (int q = 8; q < 12; q++) begin
        compare_tail(q);
    end
endtask

initial begin
    void'($urandom(SEED));
    errors          = 0;
    checks          = 0;
    max_low_run     = 0;
    ring_size_m     = 256;
    drop_total      = 0;
    rst             = 1'b1;
    in_queue_id     = '0;
    in_size         = '0;
    in_pass_through = 1'b0;
    in_meta         = '0;
    in_valid        = 1'b0;
    out_ready       = 1'b0;
    paddr           = '0;
    psel            = 1'b0;
    penable         = 1'b0;
    pwrite          = 1'b0;
    pwdata          = '0;
    for (int q = 0; q < NB_QUEUES; q++) begin
        model_head[q] = '0;
        model_tail[q] = '0;
    end

    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;
    @(posedge clk);
    #2;

    test_reset_values();
    test_single_items();
    test_back_to_back();
    test_drops();
    test_pass_through();
    test_back_pressure();

    // Nothing may be left over once every item was taken
    repeat (8) @(negedge clk);
    check("out_valid", 32'd0, 32'(out_valid));
    if (expected.size() != 0) begin
        errors++;
        $display("ERROR: %0d expected entries never came out", expected.size());
    end

    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
        $display("*** PASSED ***");
    end else begin
        $display("*** FAILED ***");
    end
    $finish;
end

endmodule

// ==== build.f ====
rtl/qm_pkg.sv
rtl/queue_table.sv
rtl/queue_state_fetch.sv
rtl/tail_update.sv
rtl/out_fifo.sv
rtl/apb_csr.sv
rtl/queue_manager.sv
testbench/tb_queue_manager.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_queue_manager
FILELIST  = build.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)
